// ==== verilog/scrub_pkg.sv ====
/* ECC bank shared definitions
   Code widths, word types, decode result and the Hsiao check matrix */
package scrub_pkg;

  // User data and stored codeword widths
  localparam int unsigned DATA_W = 32;
  localparam int unsigned CODE_W = 39;
  // Check bits sit above the data in every codeword
  localparam int unsigned CHK_W  = CODE_W - DATA_W;

  // Error class bit positions
  localparam int unsigned ErrCorBit = 0;
  localparam int unsigned ErrUncBit = 1;

  typedef logic [DATA_W-1:0] data_t;
  // Stored codeword, also used as the fault-injection flip mask
  typedef logic [CODE_W-1:0] code_t;
  typedef logic [CHK_W-1:0]  syndrome_t;
  // Bit 0 corrected, bit 1 uncorrectable, zero clean
  typedef logic [1:0]        ecc_err_t;

  // Result of one decoded word
  typedef struct packed {
    data_t    data;
    ecc_err_t err;
  } dec_res_t;

  // H-matrix columns for data bits 0 to 31
  // All weight three, all distinct, so no data column aliases a check bit
  localparam syndrome_t HsiaoCol [DATA_W] = '{
    7'h07, 7'h0B, 7'h13, 7'h23,
    7'h43, 7'h0D, 7'h15, 7'h25,
    7'h45, 7'h19, 7'h29, 7'h49,
    7'h31, 7'h51, 7'h61, 7'h0E,
    7'h16, 7'h26, 7'h46, 7'h1A,
    7'h2A, 7'h4A, 7'h32, 7'h52,
    7'h62, 7'h1C, 7'h2C, 7'h4C,
    7'h34, 7'h54, 7'h64, 7'h38
  };
  // Check bit k has the unit column 1 << k

endpackage

// ==== verilog/secded_enc.sv ====
/* Hsiao (39,32) SECDED encoder
   Appends seven check bits, each the parity of one row of the H-matrix */
module secded_enc (
  input  scrub_pkg::data_t data_i,
  output scrub_pkg::code_t code_o
);

  // One data mask per check bit, taken row-wise from the column table
  scrub_pkg::data_t [scrub_pkg::CHK_W-1:0] row_mask;
  scrub_pkg::syndrome_t                    check;

  // Transpose the column table into parity groups
  always_comb begin
    for (int r = 0; r < scrub_pkg::CHK_W; r++) begin
      for (int c = 0; c < scrub_pkg::DATA_W; c++) begin
        row_mask[r][c] = scrub_pkg::HsiaoCol[c][r];
      end
    end
  end

  // Even parity over each group
  always_comb begin
    for (int r = 0; r < scrub_pkg::CHK_W; r++) begin
      check[r] = ^(data_i & row_mask[r]);
    end
  end

  // Check bits on top, data below
  assign code_o = {check, data_i};

endmodule

// ==== verilog/secded_dec.sv ====
/* Hsiao (39,32) SECDED decoder
   Builds the syndrome, corrects single-bit errors and classifies the word */
module secded_dec (
  input  scrub_pkg::code_t     code_i,
  output scrub_pkg::dec_res_t  res_o,
  output scrub_pkg::syndrome_t syndrome_o
);

  scrub_pkg::data_t     data_in;
  scrub_pkg::syndrome_t chk_in;
  scrub_pkg::syndrome_t syndrome;
  scrub_pkg::data_t     data_fix;
  scrub_pkg::ecc_err_t  err;
  logic                 col_hit;

  // Split the stored codeword
  assign data_in = code_i[scrub_pkg::DATA_W-1:0];
  assign chk_in  = code_i[scrub_pkg::CODE_W-1:scrub_pkg::DATA_W];

  // Syndrome as XOR of the columns of all set bits
  always_comb begin
    syndrome = chk_in;
    for (int c = 0; c < scrub_pkg::DATA_W; c++) begin
      if (data_in[c]) begin
        syndrome = syndrome ^ scrub_pkg::HsiaoCol[c];
      end
    end
  end

  // Correction and error class
  always_comb begin
    data_fix = data_in;
    err      = '0;
    col_hit  = 1'b0;
    if (syndrome != '0) begin
      if (^syndrome) begin
        // Odd weight, look for the matching data column
        for (int c = 0; c < scrub_pkg::DATA_W; c++) begin
          if (syndrome == scrub_pkg::HsiaoCol[c]) begin
            data_fix[c] = ~data_in[c];
            col_hit     = 1'b1;
          end
        end
        // Unit syndrome means a flipped check bit, data is intact
        if ((syndrome & (syndrome - 1'b1)) == '0) begin
          col_hit = 1'b1;
        end
        if (col_hit) begin
          err[scrub_pkg::ErrCorBit] = 1'b1;
        end else begin
          // Odd weight but no column, at least three flips
          data_fix                  = data_in;
          err[scrub_pkg::ErrUncBit] = 1'b1;
        end
      end else begin
        // Even weight nonzero, double error
        err[scrub_pkg::ErrUncBit] = 1'b1;
      end
    end
  end

  assign res_o.data = data_fix;
  assign res_o.err  = err;
  assign syndrome_o = syndrome;

endmodule

// ==== verilog/ecc_sram_bank.sv ====
/* Multi-way codeword storage
   Per-way request mask, shared address, one-cycle registered read */
module ecc_sram_bank #(
  parameter int unsigned NumWays   = 2,
  parameter int unsigned BankDepth = 16
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic             [NumWays-1:0]        req_i,
  input  logic                                  we_i,
  input  logic             [$clog2(BankDepth)-1:0] addr_i,
  input  scrub_pkg::code_t                      wcode_i,
  output scrub_pkg::code_t [NumWays-1:0]        rcode_o
);

  localparam int unsigned AddrW = $clog2(BankDepth);

  // Storage array with one column of words per way
  scrub_pkg::code_t mem_q [NumWays][BankDepth];
  // Read register
  scrub_pkg::code_t [NumWays-1:0] rcode_q;

  // Write into every requested way
  always_ff @(posedge clk_i) begin
    for (int w = 0; w < NumWays; w++) begin
      if (req_i[w] && we_i) begin
        mem_q[w][addr_i] <= wcode_i;
      end
    end
  end

  // Reads load the requested ways
  // Unrequested ways keep their last value
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rcode_q <= '0;
    end else begin
      for (int w = 0; w < NumWays; w++) begin
        if (req_i[w] && !we_i) begin
          rcode_q[w] <= mem_q[w][addr_i];
        end
      end
    end
  end

  assign rcode_o = rcode_q;

  // A single entry leaves no address bits
  initial begin
    if (AddrW == 0) begin
      $error("BankDepth needs at least two entries");
    end
  end

endmodule

// ==== verilog/ecc_scrubber.sv ====
/* Background ECC scrubber
   Walks the bank in idle interconnect cycles and writes back corrected words */
module ecc_scrubber #(
  parameter int unsigned NumWays   = 2,
  parameter int unsigned BankDepth = 16
) (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  logic                                     scrub_en_i,
  output logic                                     bit_corrected_o,
  output logic                                     uncorrectable_o,
  // Interconnect request
  input  logic             [NumWays-1:0]           intc_req_i,
  input  logic                                     intc_we_i,
  input  logic             [$clog2(BankDepth)-1:0] intc_addr_i,
  input  scrub_pkg::code_t                         intc_wcode_i,
  // Bank request
  output logic             [NumWays-1:0]           bank_req_o,
  output logic                                     bank_we_o,
  output logic             [$clog2(BankDepth)-1:0] bank_addr_o,
  output scrub_pkg::code_t                         bank_wcode_o,
  // Bank read data, one cycle after the request
  input  scrub_pkg::code_t [NumWays-1:0]           bank_rcode_i
);

  localparam int unsigned AddrW = $clog2(BankDepth);

  typedef enum logic [1:0] {
    Idle,
    Read,
    Check
  } scrub_state_e;

  scrub_state_e state_d, state_q;

  logic [AddrW-1:0] scrub_addr_d, scrub_addr_q;
  logic [AddrW-1:0] next_addr;
  logic             intc_busy;

  // Scrubber's own request
  logic [NumWays-1:0] scrub_req;
  logic               scrub_we;

  // Decoded ways and the repair choice
  scrub_pkg::dec_res_t [NumWays-1:0] way_res;
  logic [NumWays-1:0]                fix_mask;
  scrub_pkg::data_t                  fix_data;
  scrub_pkg::code_t                  fix_code;
  logic                              any_uncorr;

  assign intc_busy = |intc_req_i;

  // Address advances modulo the bank depth
  assign next_addr = (scrub_addr_q == AddrW'(BankDepth - 1)) ? '0 : scrub_addr_q + 1'b1;

  // Own decoders, independent of the interconnect read path
  for (genvar w = 0; w < NumWays; w++) begin : gen_way_dec
    secded_dec u_way_dec (
      .code_i     (bank_rcode_i[w]),
      .res_o      (way_res[w]),
      .syndrome_o ()
    );
  end

  // First correctable way wins, any uncorrectable way is flagged
  always_comb begin
    fix_mask   = '0;
    fix_data   = '0;
    any_uncorr = 1'b0;
    for (int w = 0; w < NumWays; w++) begin
      if (fix_mask == '0 && way_res[w].err[scrub_pkg::ErrCorBit]) begin
        fix_mask[w] = 1'b1;
        fix_data    = way_res[w].data;
      end
      any_uncorr = any_uncorr | way_res[w].err[scrub_pkg::ErrUncBit];
    end
  end

  // Re-encode so the check bits are repaired too
  secded_enc u_fix_enc (
    .data_i (fix_data),
    .code_o (fix_code)
  );

  // Bank port, interconnect always has priority
  always_comb begin
    if (intc_busy) begin
      bank_req_o   = intc_req_i;
      bank_we_o    = intc_we_i;
      bank_addr_o  = intc_addr_i;
      bank_wcode_o = intc_wcode_i;
    end else begin
      bank_req_o   = scrub_req;
      bank_we_o    = scrub_we;
      bank_addr_o  = scrub_addr_q;
      bank_wcode_o = fix_code;
    end
  end

  // Scrub FSM
  always_comb begin
    state_d         = state_q;
    scrub_addr_d    = scrub_addr_q;
    scrub_req       = '0;
    scrub_we        = 1'b0;
    bit_corrected_o = 1'b0;
    uncorrectable_o = 1'b0;
    unique case (state_q)
      Idle: begin
        if (scrub_en_i) begin
          state_d = Read;
        end
      end
      Read: begin
        // Read all ways, only lands when the interconnect is idle
        scrub_req = '1;
        if (!intc_busy) begin
          state_d = Check;
        end
      end
      Check: begin
        if (fix_mask == '0) begin
          // Nothing to repair, report and move on
          uncorrectable_o = any_uncorr;
          scrub_addr_d    = next_addr;
          state_d         = Idle;
        end else begin
          scrub_req = fix_mask;
          scrub_we  = 1'b1;
          if (intc_busy) begin
            // Word may have been rewritten, read it again
            state_d = Read;
          end else begin
            bit_corrected_o = 1'b1;
            uncorrectable_o = any_uncorr;
            scrub_addr_d    = next_addr;
            state_d         = Idle;
          end
        end
      end
      default: begin
        state_d = Idle;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= Idle;
      scrub_addr_q <= '0;
    end else begin
      state_q      <= state_d;
      scrub_addr_q <= scrub_addr_d;
    end
  end

endmodule

// ==== verilog/scrubbed_bank_top.sv ====
/* Scrubbed ECC bank top level
   Write encoder with fault injection, scrubber, storage and read decoders */
module scrubbed_bank_top #(
  parameter int unsigned NumWays   = 2,
  parameter int unsigned BankDepth = 16
) (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  input  logic                                        scrub_en_i,
  // Interconnect port, no handshake
  input  logic                [NumWays-1:0]           intc_req_i,
  input  logic                                        intc_we_i,
  input  logic                [$clog2(BankDepth)-1:0] intc_addr_i,
  input  scrub_pkg::data_t                            intc_wdata_i,
  input  scrub_pkg::code_t                            intc_flip_i,
  output scrub_pkg::dec_res_t [NumWays-1:0]           intc_rdata_o,
  // Scrub status pulses
  output logic                                        bit_corrected_o,
  output logic                                        uncorrectable_o
);

  localparam int unsigned AddrW = $clog2(BankDepth);

  scrub_pkg::code_t intc_code;
  scrub_pkg::code_t intc_wcode;

  // Bank port driven by the scrubber
  logic             [NumWays-1:0] bank_req;
  logic                           bank_we;
  logic             [AddrW-1:0]   bank_addr;
  scrub_pkg::code_t               bank_wcode;
  scrub_pkg::code_t [NumWays-1:0] bank_rcode;

  // Interconnect write encoding
  secded_enc u_intc_enc (
    .data_i (intc_wdata_i),
    .code_o (intc_code)
  );

  // Fault injection after the encoder
  assign intc_wcode = intc_code ^ intc_flip_i;

  ecc_scrubber #(
    .NumWays   (NumWays),
    .BankDepth (BankDepth)
  ) u_scrubber (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .scrub_en_i      (scrub_en_i),
    .bit_corrected_o (bit_corrected_o),
    .uncorrectable_o (uncorrectable_o),
    .intc_req_i      (intc_req_i),
    .intc_we_i       (intc_we_i),
    .intc_addr_i     (intc_addr_i),
    .intc_wcode_i    (intc_wcode),
    .bank_req_o      (bank_req),
    .bank_we_o       (bank_we),
    .bank_addr_o     (bank_addr),
    .bank_wcode_o    (bank_wcode),
    .bank_rcode_i    (bank_rcode)
  );

  ecc_sram_bank #(
    .NumWays   (NumWays),
    .BankDepth (BankDepth)
  ) u_bank (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (bank_req),
    .we_i    (bank_we),
    .addr_i  (bank_addr),
    .wcode_i (bank_wcode),
    .rcode_o (bank_rcode)
  );

  // Interconnect read path, one decoder per way
  for (genvar w = 0; w < NumWays; w++) begin : gen_rd_dec
    secded_dec u_rd_dec (
      .code_i     (bank_rcode[w]),
      .res_o      (intc_rdata_o[w]),
      .syndrome_o ()
    );
  end

endmodule

// ==== sim/scrub_properties.sv ====
/* Scrubber bank port assertions
   Interconnect priority, single-way repair writes and status pulse rules */
module scrub_properties #(
  parameter int unsigned NumWays   = 2,
  parameter int unsigned BankDepth = 16
) (
  input logic                                     clk_i,
  input logic                                     rst_ni,
  input logic             [NumWays-1:0]           intc_req_i,
  input logic                                     intc_we_i,
  input logic             [$clog2(BankDepth)-1:0] intc_addr_i,
  input scrub_pkg::code_t                         intc_wcode_i,
  input logic             [NumWays-1:0]           bank_req_i,
  input logic                                     bank_we_i,
  input logic             [$clog2(BankDepth)-1:0] bank_addr_i,
  input scrub_pkg::code_t                         bank_wcode_i,
  input logic                                     bit_corrected_i,
  input logic                                     uncorrectable_i,
  input logic             [NumWays-1:0]           fix_mask_i,
  input logic                                     any_uncorr_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // Any interconnect request owns the bank port unchanged
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (|intc_req_i) |-> (bank_req_i == intc_req_i && bank_we_i == intc_we_i &&
                       bank_addr_i == intc_addr_i && bank_wcode_i == intc_wcode_i))
    else $error("Bank port differs from the interconnect request");

  // Repair write goes to exactly one way
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (!(|intc_req_i) && bank_we_i) |-> $onehot(bank_req_i))
    else $error("Scrubber write mask is not one-hot");

  // Clean visit stays silent
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (fix_mask_i == '0 && !any_uncorr_i) |-> !(bit_corrected_i || uncorrectable_i))
    else $error("Status pulse without any detected error");

  // Status outputs low while in reset
  assert property (@(posedge clk_i) !rst_ni |-> !(bit_corrected_i || uncorrectable_i))
    else $error("Status pulse during reset");

endmodule

bind ecc_scrubber scrub_properties #(
  .NumWays   (NumWays),
  .BankDepth (BankDepth)
) u_scrub_props (
  .clk_i           (clk_i),
  .rst_ni          (rst_ni),
  .intc_req_i      (intc_req_i),
  .intc_we_i       (intc_we_i),
  .intc_addr_i     (intc_addr_i),
  .intc_wcode_i    (intc_wcode_i),
  .bank_req_i      (bank_req_o),
  .bank_we_i       (bank_we_o),
  .bank_addr_i     (bank_addr_o),
  .bank_wcode_i    (bank_wcode_o),
  .bit_corrected_i (bit_corrected_o),
  .uncorrectable_i (uncorrectable_o),
  .fix_mask_i      (fix_mask),
  .any_uncorr_i    (any_uncorr)
);

// ==== sim/tb_scrubbed_bank.sv ====
/* Scrubbed ECC bank testbench
   Random writes with fault injection, read checks and scrub repair against a model */
module tb_scrubbed_bank;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned NumWays     = 2;
  localparam int unsigned BankDepth   = 16;
  localparam int unsigned AddrW       = $clog2(BankDepth);
  localparam int unsigned NumWords    = NumWays * BankDepth;
  localparam int unsigned NumRandOps  = 400;
  // Idle, Read and Check, one address per visit
  localparam int unsigned VisitCycles = 3;
  localparam int unsigned QuietCycles = 2 * VisitCycles * BankDepth;
  localparam int unsigned RepairBound = (NumWays + 2) * VisitCycles * BankDepth;
  localparam int unsigned TotalOps    = 4 * NumWords + NumRandOps;
  localparam int unsigned CycleMargin = 4;
  localparam int unsigned TimeoutCycles = TotalOps * BankDepth * CycleMargin;

  logic                              clk_i;
  logic                              rst_ni;
  logic                              scrub_en_i;
  logic [NumWays-1:0]                intc_req_i;
  logic                              intc_we_i;
  logic [AddrW-1:0]                  intc_addr_i;
  scrub_pkg::data_t                  intc_wdata_i;
  scrub_pkg::code_t                  intc_flip_i;
  scrub_pkg::dec_res_t [NumWays-1:0] intc_rdata_o;
  logic                              bit_corrected_o;
  logic                              uncorrectable_o;

  // Reference model, written data and injected flips per way and address
  scrub_pkg::data_t model_data [NumWays][BankDepth];
  scrub_pkg::code_t model_flip [NumWays][BankDepth];

  logic [31:0] seed_q = 32'ha66f;
  int unsigned cor_pulses = 0;
  int unsigned unc_pulses = 0;
  int unsigned data_errs  = 0;
  int unsigned class_errs = 0;
  int unsigned count_errs = 0;
  int unsigned other_errs = 0;

  scrubbed_bank_top UUT (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .scrub_en_i      (scrub_en_i),
    .intc_req_i      (intc_req_i),
    .intc_we_i       (intc_we_i),
    .intc_addr_i     (intc_addr_i),
    .intc_wdata_i    (intc_wdata_i),
    .intc_flip_i     (intc_flip_i),
    .intc_rdata_o    (intc_rdata_o),
    .bit_corrected_o (bit_corrected_o),
    .uncorrectable_o (uncorrectable_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Status pulses are combinational, count them mid-cycle
  always @(negedge clk_i) begin
    if (rst_ni && bit_corrected_o) cor_pulses++;
    if (rst_ni && uncorrectable_o) unc_pulses++;
  end

  initial begin
    repeat (TimeoutCycles) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles, the run did not finish", TimeoutCycles);
    $display("*** TEST FAILED ***");
    $finish;
  end

  function automatic logic [31:0] xorshift(logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic logic [31:0] next_rand();
    seed_q = xorshift(seed_q);
    return seed_q;
  endfunction

  // Flip mask with pop distinct set bits, pop up to two
  function automatic scrub_pkg::code_t make_flip(int unsigned pop);
    scrub_pkg::code_t flip;
    int unsigned      p1;
    int unsigned      p2;
    flip = '0;
    p1   = next_rand() % scrub_pkg::CODE_W;
    p2   = (p1 + 1 + next_rand() % (scrub_pkg::CODE_W - 1)) % scrub_pkg::CODE_W;
    if (pop > 0) flip[p1] = 1'b1;
    if (pop > 1) flip[p2] = 1'b1;
    return flip;
  endfunction

  // SECDED class follows from the number of flipped bits
  function automatic scrub_pkg::ecc_err_t expected_class(scrub_pkg::code_t flip);
    case ($countones(flip))
      0:       return 2'b00;
      1:       return 2'b01;
      default: return 2'b10;
    endcase
  endfunction

  function automatic int unsigned count_single();
    int unsigned n;
    n = 0;
    for (int w = 0; w < NumWays; w++) begin
      for (int a = 0; a < BankDepth; a++) begin
        if ($countones(model_flip[w][a]) == 1) n++;
      end
    end
    return n;
  endfunction

  task automatic check_data(string name, scrub_pkg::data_t exp, scrub_pkg::data_t act);
    if (exp !== act) begin
      data_errs++;
      $display("ERR %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_err(string name, scrub_pkg::ecc_err_t exp, scrub_pkg::ecc_err_t act);
    if (exp !== act) begin
      class_errs++;
      $display("ERR %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_count(string name, int unsigned exp, int unsigned act);
    if (exp != act) begin
      count_errs++;
      $display("ERR %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic drive_idle();
    @(posedge clk_i);
    intc_req_i <= '0;
    intc_we_i  <= 1'b0;
  endtask

  task automatic write_word(logic [NumWays-1:0] mask, logic [AddrW-1:0] addr,
                            scrub_pkg::data_t data, scrub_pkg::code_t flip);
    @(posedge clk_i);
    intc_req_i   <= mask;
    intc_we_i    <= 1'b1;
    intc_addr_i  <= addr;
    intc_wdata_i <= data;
    intc_flip_i  <= flip;
    for (int w = 0; w < NumWays; w++) begin
      if (mask[w]) begin
        model_data[w][addr] = data;
        model_flip[w][addr] = flip;
      end
    end
  endtask

  // Read the masked ways, result is due in the cycle after the request
  task automatic read_check(logic [NumWays-1:0] mask, logic [AddrW-1:0] addr,
                            logic scrub_on);
    string name;
    int    pop;
    @(posedge clk_i);
    intc_req_i  <= mask;
    intc_we_i   <= 1'b0;
    intc_addr_i <= addr;
    @(posedge clk_i);
    intc_req_i  <= '0;
    @(negedge clk_i);
    for (int w = 0; w < NumWays; w++) begin
      if (mask[w]) begin
        name = $sformatf("read way %0d addr %0d", w, addr);
        pop  = $countones(model_flip[w][addr]);
        // Two flips leave the data undefined
        if (pop < 2) check_data(name, model_data[w][addr], intc_rdata_o[w].data);
        // A single flip may already be repaired by the scrubber
        if (!(scrub_on && pop == 1 && intc_rdata_o[w].err == 2'b00)) begin
          check_err(name, expected_class(model_flip[w][addr]), intc_rdata_o[w].err);
        end
      end
    end
  endtask

  task automatic read_all(logic scrub_on);
    for (int a = 0; a < BankDepth; a++) begin
      read_check('1, AddrW'(a), scrub_on);
    end
  endtask

  // Scrub repaired every single flip, model words become clean
  task automatic clear_single();
    for (int w = 0; w < NumWays; w++) begin
      for (int a = 0; a < BankDepth; a++) begin
        if ($countones(model_flip[w][a]) == 1) model_flip[w][a] = '0;
      end
    end
  endtask

  task automatic wait_repairs(int unsigned base, int unsigned exp);
    int unsigned cycles;
    cycles = 0;
    while (cor_pulses - base < exp && cycles < RepairBound) begin
      @(posedge clk_i);
      cycles++;
    end
    if (cor_pulses - base < exp) begin
      other_errs++;
      $display("Scrubber did not repair all single-bit errors in time");
    end
  endtask

  // Two full passes without a repair means nothing is left to fix
  task automatic wait_quiet();
    int unsigned last;
    int unsigned quiet;
    int unsigned cycles;
    last   = cor_pulses;
    quiet  = 0;
    cycles = 0;
    while (quiet < QuietCycles && cycles < RepairBound + QuietCycles) begin
      @(posedge clk_i);
      cycles++;
      quiet = (cor_pulses == last) ? quiet + 1 : 0;
      last  = cor_pulses;
    end
    if (quiet < QuietCycles) begin
      other_errs++;
      $display("Scrubber kept reporting repairs and never settled");
    end
  endtask

  initial begin : main
    int unsigned        op;
    int unsigned        base_cor;
    int unsigned        base_unc;
    int unsigned        exp_cnt;
    int unsigned        total;
    logic [NumWays-1:0] mask;
    logic [AddrW-1:0]   addr;
    scrub_pkg::data_t   data;
    scrub_pkg::code_t   flip;
    rst_ni       = 1'b0;
    scrub_en_i   = 1'b0;
    intc_req_i   = '0;
    intc_we_i    = 1'b0;
    intc_addr_i  = '0;
    intc_wdata_i = '0;
    intc_flip_i  = '0;
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;

    // After reset, no requests and scrubbing off
    repeat (8) @(posedge clk_i);
    check_count("corrected pulses after reset", 0, cor_pulses);
    check_count("uncorrectable pulses after reset", 0, unc_pulses);

    // Clean round trip
    for (int i = 0; i < NumWords; i++) begin
      write_word(NumWays'(1 << (i % NumWays)), AddrW'(i / NumWays), next_rand(), '0);
    end
    read_all(1'b0);

    // Injected flips, mixed one and two bit errors
    for (int i = 0; i < NumWords; i++) begin
      data = next_rand();
      flip = make_flip(i % 3);
      write_word(NumWays'(1 << (i % NumWays)), AddrW'(i / NumWays), data, flip);
    end
    drive_idle();
    read_all(1'b0);

    // Scrub repair with an idle interconnect
    exp_cnt  = count_single();
    base_cor = cor_pulses;
    base_unc = unc_pulses;
    @(posedge clk_i);
    scrub_en_i <= 1'b1;
    wait_repairs(base_cor, exp_cnt);
    wait_quiet();
    check_count("scrub repair pulses", exp_cnt, cor_pulses - base_cor);
    if (unc_pulses == base_unc) begin
      other_errs++;
      $display("Scrubber never reported an uncorrectable word");
    end
    clear_single();
    read_all(1'b1);

    // Random traffic while the scrubber runs
    for (int i = 0; i < NumRandOps; i++) begin
      op   = next_rand() % 8;
      mask = NumWays'(next_rand() % ((1 << NumWays) - 1) + 1);
      addr = AddrW'(next_rand() % BankDepth);
      data = next_rand();
      flip = make_flip(next_rand() % 3);
      if (op < 4) begin
        read_check(mask, addr, 1'b1);
      end else if (op < 7) begin
        write_word(mask, addr, data, flip);
      end else begin
        drive_idle();
        drive_idle();
      end
    end
    drive_idle();
    wait_quiet();
    clear_single();
    read_all(1'b1);

    total = data_errs + class_errs + count_errs + other_errs;
    $display("Errors: data %0d, class %0d, count %0d, other %0d",
             data_errs, class_errs, count_errs, other_errs);
    if (total == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
verilog/scrub_pkg.sv
verilog/secded_enc.sv
verilog/secded_dec.sv
verilog/ecc_sram_bank.sv
verilog/ecc_scrubber.sv
verilog/scrubbed_bank_top.sv
sim/scrub_properties.sv
sim/tb_scrubbed_bank.sv

// ==== Bender.yml ====
package:
  name: scrubbed_bank

sources:
  - files:
      - verilog/scrub_pkg.sv
      - verilog/secded_enc.sv
      - verilog/secded_dec.sv
      - verilog/ecc_sram_bank.sv
      - verilog/ecc_scrubber.sv
      - verilog/scrubbed_bank_top.sv
  - target: simulation
    files:
      - sim/scrub_properties.sv
      - sim/tb_scrubbed_bank.sv
